/* dv/mem_trace.txt */
// columns are op, address, store data, flag and expected load data in hex
// flag 0 is a load, 1 a store, 2 a reset of the unit before a load
3 080 0000000000000000 0 dddcdfded9d8dbda
1 088 0000000000000000 0 ffffffffffffffd2
5 089 0000000000000000 0 00000000000000d3
1 08a 0000000000000000 0 ffffffffffffffd0
5 08b 0000000000000000 0 00000000000000d1
1 08c 0000000000000000 0 ffffffffffffffd6
5 08d 0000000000000000 0 00000000000000d7
1 08e 0000000000000000 0 ffffffffffffffd4
5 08f 0000000000000000 0 00000000000000d5
2 080 0000000000000000 0 ffffffffffffdbda
6 082 0000000000000000 0 000000000000d9d8
2 084 0000000000000000 0 ffffffffffffdfde
6 086 0000000000000000 0 000000000000dddc
0 088 0000000000000000 0 ffffffffd1d0d3d2
4 08c 0000000000000000 0 00000000d5d4d7d6
0 084 0000000000000000 0 ffffffffdddcdfde
4 080 0000000000000000 0 00000000d9d8dbda
1 043 11223344556677a5 1 0000000000000000
2 046 00000000ffffbeef 1 0000000000000000
3 048 0000000000000000 0 1514171611101312
0 04c 99999999cafef00d 1 0000000000000000
3 040 0000000000000000 0 beef1f1ea5181b1a
3 048 0000000000000000 0 cafef00d11101312
3 140 0000000000000000 0 1c1d1e1f18191a1b // evicts the dirty line at 040
3 040 0000000000000000 0 beef1f1ea5181b1a // refilled from the written back line
3 048 0000000000000000 0 cafef00d11101312
3 080 0000000000000000 2 dddcdfded9d8dbda // loaded before the reset yet misses again
3 048 0000000000000000 0 cafef00d11101312
1 045 0000000000000000 0 000000000000001f

/* sources.f */
design/mem_pkg.sv
design/dcache_pkg.sv
design/dcache_if.sv
design/mem_stage.sv
design/dcache_ctrl.sv
design/dcache_sweep.sv
design/dcache_store.sv
design/mem_top.sv
dv/tb_clock.sv
dv/mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* dv/mem_tb.sv */
// load store unit testbench
module mem_tb;
    import mem_pkg::*;
    import dcache_pkg::*;

    logic    clk;
    logic    rst;
    mem_op_t mem_op;
    addr_t   addr;
    dword_t  wdata;
    logic    mem_wen;
    logic    vis_mem;
    dword_t  rdata;
    logic    busy;
    addr_t   d_rw_addr;
    logic    d_rw_req;
    logic    d_rw_valid;
    line_t   d_rw_w_data;
    line_t   d_data_read;
    logic    d_rw_ready;

    line_t       mem_lines [256];  // 4 KB backing memory
    logic [63:0] tr_op [$];
    logic [63:0] tr_addr [$];
    logic [63:0] tr_wdata [$];
    logic [63:0] tr_flag [$];
    logic [63:0] tr_exp [$];
    int          tr_line [$];

    int mismatch_count = 0;
    int fault_count    = 0;
    int xfer_count     = 0;
    int cycle_count    = 0;
    int cycle_limit    = 1000000;  // replaced once the trace is read

    tb_clock u_clock (.clk_o(clk));

    mem_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .mem_op_i      (mem_op),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .mem_wen_i     (mem_wen),
        .vis_mem_i     (vis_mem),
        .rdata_o       (rdata),
        .busy_o        (busy),
        .d_rw_addr_o   (d_rw_addr),
        .d_rw_req_o    (d_rw_req),
        .d_rw_valid_o  (d_rw_valid),
        .d_rw_w_data_o (d_rw_w_data),
        .d_data_read_i (d_data_read),
        .d_rw_ready_i  (d_rw_ready)
    );

    // low address byte xor 5a folded with the upper address bits
    function automatic logic [7:0] pattern_byte(input logic [11:0] a);
        return a[7:0] ^ 8'h5a ^ {4'h0, a[11:8]};
    endfunction

    task automatic check_value(input int line_no, input dword_t expected, input dword_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH trace line %0d expected %h actual %h", line_no, expected, actual);
        end
    endtask

    task automatic serve_transfer();
        logic [7:0] line_idx;
        line_idx = d_rw_addr[11:4];
        if (d_rw_addr[63:12] != '0) begin
            fault_count++;
            $display("memory access outside the 4 KB model at address %h", d_rw_addr);
        end
        if (d_rw_req) begin
            mem_lines[line_idx] = d_rw_w_data;
        end else begin
            d_data_read = mem_lines[line_idx];
        end
        d_rw_ready = 1'b1;
        xfer_count++;
    endtask

    task automatic load_trace();
        int          fd;
        int          line_no;
        int          got;
        string       text;
        logic [63:0] f_op, f_addr, f_wdata, f_flag, f_exp;
        fd = $fopen("dv/mem_trace.txt", "r");
        if (fd == 0) begin
            fault_count++;
            $display("cannot open the trace file dv/mem_trace.txt");
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line_no++;
            got = $fgets(text, fd);
            if (got > 0 && $sscanf(text, "%h %h %h %h %h",
                                   f_op, f_addr, f_wdata, f_flag, f_exp) == 5) begin
                tr_op.push_back(f_op);
                tr_addr.push_back(f_addr);
                tr_wdata.push_back(f_wdata);
                tr_flag.push_back(f_flag);
                tr_exp.push_back(f_exp);
                tr_line.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        rst     = 1'b1;
        vis_mem = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_access(input int idx, input bit fresh);
        int cycles;
        int xfers_before;
        mem_op       = mem_op_t'(tr_op[idx][2:0]);
        addr         = tr_addr[idx];
        wdata        = tr_wdata[idx];
        mem_wen      = (tr_flag[idx] == 64'd1);
        vis_mem      = 1'b1;
        xfers_before = xfer_count;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy);
        if (!mem_wen) begin
            check_value(tr_line[idx], tr_exp[idx], rdata);
        end
        if (d_rw_valid) begin
            fault_count++;
            $display("trace line %0d completed while a memory transfer was still open",
                     tr_line[idx]);
        end
        if (fresh && cycles <= 16) begin
            fault_count++;
            $display("trace line %0d completed within the reset sweep", tr_line[idx]);
        end
        if (fresh && xfer_count == xfers_before) begin
            fault_count++;
            $display("trace line %0d hit in the cache right after reset", tr_line[idx]);
        end
        @(negedge clk);  // hold through the completion edge
        vis_mem = 1'b0;
    endtask

    task automatic finish_run();
        $display("summary %0d mismatches, %0d other errors over %0d accesses",
                 mismatch_count, fault_count, tr_op.size());
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // main memory with 0 to 5 cycles of random delay per transfer
    initial begin : memory_model
        int   wait_left;
        logic in_xfer;
        void'($urandom(32'h1a2f242e));
        d_rw_ready  = 1'b0;
        d_data_read = '0;
        in_xfer     = 1'b0;
        wait_left   = 0;
        for (int l = 0; l < 256; l++) begin
            for (int b = 0; b < 16; b++) begin
                mem_lines[l][b*8 +: 8] = pattern_byte(12'(l * 16 + b));
            end
        end
        forever begin
            @(negedge clk);
            if (rst) begin
                d_rw_ready = 1'b0;
                in_xfer    = 1'b0;
            end else if (d_rw_ready) begin
                d_rw_ready = 1'b0;  // taken at the last rising edge
                in_xfer    = 1'b0;
            end else if (in_xfer && !d_rw_valid) begin
                fault_count++;
                $display("memory port valid dropped before ready at time %0t", $time);
                in_xfer = 1'b0;
            end else if (in_xfer || d_rw_valid) begin
                if (!in_xfer) begin
                    in_xfer   = 1'b1;
                    wait_left = $urandom_range(5, 0);
                end
                if (wait_left == 0) begin
                    serve_transfer();
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        fault_count++;
        $display("timeout after %0d cycles, the run hung", cycle_count);
        finish_run();
    end

    initial begin : main_seq
        bit fresh;
        rst     = 1'b1;
        mem_op  = LW;
        addr    = '0;
        wdata   = '0;
        mem_wen = 1'b0;
        vis_mem = 1'b0;
        load_trace();
        cycle_limit = tr_op.size() * 40 + 100;
        if (tr_op.size() == 0) begin
            fault_count++;
            $display("no accesses found in the trace file");
        end
        apply_reset();
        fresh = 1'b1;
        foreach (tr_op[i]) begin
            if (tr_flag[i] == 64'd2) begin
                apply_reset();
                fresh = 1'b1;
            end
            run_access(i, fresh);
            fresh = 1'b0;
        end
        finish_run();
    end

endmodule

/* dv/tb_clock.sv */
// testbench clock source
module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;  // 20 unit period
        end
    end

endmodule

/* design/mem_top.sv */
// load store unit top
module mem_top (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_op_t  mem_op_i,
    input  mem_pkg::addr_t    addr_i,
    input  mem_pkg::dword_t   wdata_i,
    input  logic              mem_wen_i,
    input  logic              vis_mem_i,
    output mem_pkg::dword_t   rdata_o,
    output logic              busy_o,
    output mem_pkg::addr_t    d_rw_addr_o,
    output logic              d_rw_req_o,
    output logic              d_rw_valid_o,
    output dcache_pkg::line_t d_rw_w_data_o,
    input  dcache_pkg::line_t d_data_read_i,
    input  logic              d_rw_ready_i
);
    logic sweep_done;

    cpu_cache_if u_cpu_if ();
    array_if     u_arr_ctrl ();
    array_if     u_arr_sweep ();
    array_if     u_arr_store ();

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .mem_op_i  (mem_op_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .mem_wen_i (mem_wen_i),
        .vis_mem_i (vis_mem_i),
        .rdata_o   (rdata_o),
        .busy_o    (busy_o),
        .cpu       (u_cpu_if.cpu)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .sweep_done_i  (sweep_done),
        .cpu           (u_cpu_if.cache),
        .arr           (u_arr_ctrl.ctrl),
        .d_rw_addr_o   (d_rw_addr_o),
        .d_rw_req_o    (d_rw_req_o),
        .d_rw_valid_o  (d_rw_valid_o),
        .d_rw_w_data_o (d_rw_w_data_o),
        .d_data_read_i (d_data_read_i),
        .d_rw_ready_i  (d_rw_ready_i)
    );

    dcache_sweep u_sweep (
        .clk          (clk),
        .rst          (rst),
        .arr          (u_arr_sweep.sweep),
        .sweep_done_o (sweep_done)
    );

    dcache_store u_store (
        .clk (clk),
        .cpu (u_cpu_if.cache),
        .arr (u_arr_store.store)
    );

    // sweep owns the array index until it finishes
    assign u_arr_store.index     = sweep_done ? u_arr_ctrl.index : u_arr_sweep.index;
    assign u_arr_store.clear_we  = u_arr_sweep.clear_we;
    assign u_arr_store.tag_we    = u_arr_ctrl.tag_we;
    assign u_arr_store.fill_we   = u_arr_ctrl.fill_we;
    assign u_arr_store.fill_line = u_arr_ctrl.fill_line;
    assign u_arr_store.store_we  = u_arr_ctrl.store_we;

    assign u_arr_ctrl.hit          = u_arr_store.hit;
    assign u_arr_ctrl.victim_dirty = u_arr_store.victim_dirty;
    assign u_arr_ctrl.victim_tag   = u_arr_store.victim_tag;
    assign u_arr_ctrl.rd_line      = u_arr_store.rd_line;

endmodule

/* design/dcache_store.sv */
// cache tag and data arrays
module dcache_store (
    input  logic       clk,
    cpu_cache_if.cache cpu,
    array_if.store     arr
);
    import mem_pkg::*;
    import dcache_pkg::*;

    tag_t            tags_q [SETS];
    line_t           data_q [SETS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    tag_t   req_tag;
    dword_t old_half;
    dword_t new_half;
    line_t  merged;

    assign req_tag = cpu.req_addr[63 -: TAG_W];

    assign arr.rd_line      = data_q[arr.index];
    assign arr.victim_tag   = tags_q[arr.index];
    assign arr.victim_dirty = valid_q[arr.index] && dirty_q[arr.index];
    assign arr.hit          = valid_q[arr.index] && (tags_q[arr.index] == req_tag);

    // address bit 3 picks the half
    assign old_half       = cpu.req_addr[3] ? arr.rd_line[127:64] : arr.rd_line[63:0];
    assign cpu.resp_rdata = old_half;

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            new_half[b*8 +: 8] = cpu.req_wmask[b] ? cpu.req_wdata[b*8 +: 8] : old_half[b*8 +: 8];
        end
        merged = cpu.req_addr[3] ? {new_half, arr.rd_line[63:0]}
                                 : {arr.rd_line[127:64], new_half};
    end

    always_ff @(posedge clk) begin
        if (arr.clear_we) begin
            valid_q[arr.index] <= 1'b0;
            dirty_q[arr.index] <= 1'b0;
        end else if (arr.tag_we) begin
            tags_q[arr.index]  <= req_tag;
            valid_q[arr.index] <= 1'b1;
            dirty_q[arr.index] <= 1'b0;  // fresh from memory
        end else if (arr.store_we) begin
            dirty_q[arr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.fill_we) begin
            data_q[arr.index] <= arr.fill_line;
        end else if (arr.store_we) begin
            data_q[arr.index] <= merged;
        end
    end

endmodule

/* design/dcache_sweep.sv */
// post reset valid and dirty clear
module dcache_sweep (
    input  logic   clk,
    input  logic   rst,
    array_if.sweep arr,
    output logic   sweep_done_o
);
    import dcache_pkg::*;

    index_t set_q;
    logic   done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            set_q  <= '0;
            done_q <= 1'b0;
        end else if (!done_q) begin
            set_q <= set_q + 1'b1;
            if (set_q == index_t'(SETS - 1)) done_q <= 1'b1;
        end
    end

    assign arr.index    = set_q;
    assign arr.clear_we = !done_q;
    assign sweep_done_o = done_q;

endmodule

/* design/dcache_ctrl.sv */
// data cache controller
module dcache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              sweep_done_i,
    cpu_cache_if.cache        cpu,
    array_if.ctrl             arr,
    output mem_pkg::addr_t    d_rw_addr_o,
    output logic              d_rw_req_o,
    output logic              d_rw_valid_o,
    output dcache_pkg::line_t d_rw_w_data_o,
    input  dcache_pkg::line_t d_data_read_i,
    input  logic              d_rw_ready_i
);
    import mem_pkg::*;
    import dcache_pkg::*;

    cache_state_t state_q;
    logic         valid_q;
    addr_t        addr_q;
    logic         rw_q;
    logic         fill;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= SWEEP;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                SWEEP: if (sweep_done_i) state_q <= IDLE;
                IDLE: if (cpu.req_valid) state_q <= LOOKUP;
                LOOKUP: begin
                    if (arr.hit) begin
                        state_q <= RESPOND;
                    end else begin
                        valid_q <= 1'b1;
                        state_q <= arr.victim_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (d_rw_ready_i) begin
                        valid_q <= 1'b0;  // drop for a cycle before the refill
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (!valid_q) begin
                        valid_q <= 1'b1;
                    end else if (d_rw_ready_i) begin
                        valid_q <= 1'b0;
                        state_q <= LOOKUP;  // retry, now a hit
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= SWEEP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu.req_valid) begin
            addr_q <= cpu.req_addr;
            rw_q   <= cpu.req_rw;
        end
    end

    assign cpu.idle       = (state_q == IDLE);
    assign cpu.resp_ready = (state_q == RESPOND);

    assign fill          = (state_q == REFILL) && valid_q && d_rw_ready_i;
    assign arr.index     = addr_q[OFFSET_W +: INDEX_W];
    assign arr.tag_we    = fill;
    assign arr.fill_we   = fill;
    assign arr.fill_line = d_data_read_i;
    assign arr.store_we  = (state_q == LOOKUP) && arr.hit && rw_q;

    assign d_rw_valid_o  = valid_q;
    assign d_rw_req_o    = (state_q == WRITEBACK);
    assign d_rw_w_data_o = arr.rd_line;
    assign d_rw_addr_o   = d_rw_req_o ? {arr.victim_tag, arr.index, {OFFSET_W{1'b0}}}
                                      : {addr_q[63:OFFSET_W], {OFFSET_W{1'b0}}};

endmodule

/* design/mem_stage.sv */
// memory stage lane alignment
module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  mem_pkg::mem_op_t mem_op_i,
    input  mem_pkg::addr_t   addr_i,
    input  mem_pkg::dword_t  wdata_i,
    input  logic             mem_wen_i,
    input  logic             vis_mem_i,
    output mem_pkg::dword_t  rdata_o,
    output logic             busy_o,
    cpu_cache_if.cpu         cpu
);
    import mem_pkg::*;

    logic       pending_q;
    logic [5:0] shamt;
    bmask_t     size_mask;
    dword_t     size_bits;
    dword_t     lane_data;

    assign shamt = {addr_i[2:0], 3'b000};  // bit offset of the lane

    always_comb begin
        case (mem_op_i[1:0])
            2'b01: begin
                size_mask = 8'h01;
                size_bits = 64'h0000_0000_0000_00ff;
            end
            2'b10: begin
                size_mask = 8'h03;
                size_bits = 64'h0000_0000_0000_ffff;
            end
            2'b00: begin
                size_mask = 8'h0f;
                size_bits = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                size_mask = 8'hff;
                size_bits = '1;
            end
        endcase
    end

    assign cpu.req_addr  = addr_i;
    assign cpu.req_rw    = mem_wen_i;
    assign cpu.req_wmask = size_mask << addr_i[2:0];
    assign cpu.req_wdata = (wdata_i & size_bits) << shamt;

    // one request per access
    assign cpu.req_valid = vis_mem_i && !pending_q && cpu.idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (cpu.resp_ready) begin
            pending_q <= 1'b0;
        end else if (cpu.req_valid) begin
            pending_q <= 1'b1;
        end
    end

    assign busy_o = vis_mem_i && !cpu.resp_ready;

    assign lane_data = cpu.resp_rdata >> shamt;

    always_comb begin
        case (mem_op_i)
            LW:      rdata_o = {{32{lane_data[31]}}, lane_data[31:0]};
            LB:      rdata_o = {{56{lane_data[7]}}, lane_data[7:0]};
            LH:      rdata_o = {{48{lane_data[15]}}, lane_data[15:0]};
            LD:      rdata_o = lane_data;
            LWU:     rdata_o = {32'b0, lane_data[31:0]};
            LBU:     rdata_o = {56'b0, lane_data[7:0]};
            LHU:     rdata_o = {48'b0, lane_data[15:0]};
            default: rdata_o = '0;
        endcase
    end

endmodule

/* design/dcache_if.sv */
// cpu to cache and controller to array links
interface cpu_cache_if;
    import mem_pkg::*;

    addr_t  req_addr;
    logic   req_rw;     // 1 means write
    logic   req_valid;
    dword_t req_wdata;
    bmask_t req_wmask;
    dword_t resp_rdata;
    logic   resp_ready;
    logic   idle;

    modport cpu (output req_addr, req_rw, req_valid, req_wdata, req_wmask,
                 input resp_rdata, resp_ready, idle);
    modport cache (input req_addr, req_rw, req_valid, req_wdata, req_wmask,
                   output resp_rdata, resp_ready, idle);
endinterface

interface array_if;
    import dcache_pkg::*;

    index_t index;
    logic   hit;
    logic   victim_dirty;
    tag_t   victim_tag;
    line_t  rd_line;
    logic   tag_we;
    logic   fill_we;
    line_t  fill_line;
    logic   store_we;
    logic   clear_we;

    modport ctrl (output index, tag_we, fill_we, fill_line, store_we,
                  input hit, victim_dirty, victim_tag, rd_line);
    modport store (input index, tag_we, fill_we, fill_line, store_we, clear_we,
                   output hit, victim_dirty, victim_tag, rd_line);
    modport sweep (output index, clear_we);
endinterface

/* design/dcache_pkg.sv */
// data cache geometry and types
package dcache_pkg;

    localparam int SETS     = 16;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = 4;   // 16 bytes per line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 56;

    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } cache_state_t;

endpackage

/* design/mem_pkg.sv */
// cpu side access types
package mem_pkg;

    typedef logic [63:0] addr_t;   // byte address
    typedef logic [63:0] dword_t;  // store data, load data, line half
    typedef logic [7:0]  bmask_t;  // one bit per byte lane

    // low two bits give the size, high bit selects zero extension
    typedef enum logic [2:0] {
        LW  = 3'b000,
        LB  = 3'b001,
        LH  = 3'b010,
        LD  = 3'b011,
        LWU = 3'b100,
        LBU = 3'b101,
        LHU = 3'b110
    } mem_op_t;

endpackage
